/* arm_bus_pkg.sv */
package arm_bus_pkg;

	localparam logic [31:0] STATUS_REQUEST_HEADER     = 32'h1CE1CEBB;
	localparam logic [31:0] M3_STATUS_RESPONSE_HEADER = 32'hDABAD000;
	localparam logic [31:0] M3_COMMAND_HEADER         = 32'hCAFEBABE;
	localparam logic [31:0] M3_CONTROL_MODE_HEADER    = 32'hCAFED00D;

	// frame lengths in bytes, header and crc included
	localparam int HEADER_LENGTH             = 4;
	localparam int STATUS_REQUEST_LENGTH     = 7;
	localparam int M3_COMMAND_LENGTH         = 11;
	localparam int M3_CONTROL_MODE_LENGTH    = 12;
	localparam int M3_STATUS_RESPONSE_LENGTH = 28;

	typedef enum logic [1:0] {STATUS_REQUEST, COMMAND, CONTROL_MODE} frame_kind_e;

	typedef struct packed {
		logic [7:0]         id;
		logic [7:0]         control_mode;
		logic signed [31:0] setpoint;
	} motor_cfg_t;

	typedef struct packed {
		logic signed [31:0] encoder0_position;
		logic signed [31:0] encoder1_position;
		logic signed [31:0] displacement;
		logic signed [31:0] duty;
	} motor_status_t;

	typedef enum logic [31:0] {
		RX_OK       = 32'h0000_0000,
		RX_BUSY     = 32'h0000_0001,
		RX_WRONG_ID = 32'h0000_0003,
		RX_BAD_CRC  = 32'hBAAD_C0DE,
		RX_TIMEOUT  = 32'hDEAD_BEAF
	} rx_code_e;

	typedef struct packed {
		logic ok;
		logic mode_mismatch;
		logic setpoint_mismatch;
	} rx_result_t;

	typedef enum logic [2:0] {IDLE, REQUEST, WAIT_RESPONSE, UPDATE, WAIT_SENT} sched_state_e;

	// crc-16, poly 0x1021, msb first
	function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] data);
		logic [15:0] c;
		c = crc ^ {data, 8'h00};
		for (int i = 0; i < 8; i++)
			c = c[15] ? ((c << 1) ^ 16'h1021) : (c << 1);
		return c;
	endfunction

endpackage

/* uart_tx.sv */
`timescale 1ns/1ns

module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       busy,
	output logic       tx,
	output logic       tx_enable
);
	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW-1:0] LAST_CLK = CW'(CLKS_PER_BIT - 1);

	logic [CW-1:0] clk_cnt;
	logic [3:0]    bit_cnt;
	logic [8:0]    shift; // data bits then stop bit

	assign tx_enable = busy; // drive the bus only while a byte is on the line

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			tx <= 1'b1;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (tx_start) begin
				busy <= 1'b1;
				tx <= 1'b0; // start bit
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (clk_cnt == LAST_CLK) begin
			clk_cnt <= '0;
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
				tx <= 1'b1;
			end else
				tx <= shift[0];
		end else
			clk_cnt <= clk_cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!busy && tx_start)
			shift <= {1'b1, tx_byte};
		else if (busy && clk_cnt == LAST_CLK)
			shift <= shift >> 1;
	end

endmodule

/* uart_rx.sv */
`timescale 1ns/1ns

module uart_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic       rx_valid,
	output logic [7:0] rx_byte
);
	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW-1:0] LAST_CLK = CW'(CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] HALF_CLK = CW'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {R_IDLE, R_START, R_DATA, R_STOP} rx_state_e;

	rx_state_e     state;
	logic [1:0]    sync;
	logic [CW-1:0] clk_cnt;
	logic [2:0]    bit_cnt;
	logic [7:0]    shift;
	logic          line;

	assign line = sync[1];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= R_IDLE;
			sync <= 2'b11;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			sync <= {sync[0], rx};
			rx_valid <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				R_IDLE: begin
					clk_cnt <= '0;
					if (!line)
						state <= R_START;
				end
				R_START: if (clk_cnt == HALF_CLK) begin // middle of start bit
					clk_cnt <= '0;
					bit_cnt <= '0;
					state <= line ? R_IDLE : R_DATA;
				end
				R_DATA: if (clk_cnt == LAST_CLK) begin
					clk_cnt <= '0;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7)
						state <= R_STOP;
				end
				R_STOP: if (clk_cnt == LAST_CLK) begin
					rx_valid <= line; // framing error drops the byte
					state <= R_IDLE;
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == R_DATA && clk_cnt == LAST_CLK)
			shift <= {line, shift[7:1]}; // lsb first
		if (state == R_STOP && clk_cnt == LAST_CLK)
			rx_byte <= shift;
	end

endmodule

/* frame_sender.sv */
`timescale 1ns/1ns

module frame_sender (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     send,
	input  arm_bus_pkg::frame_kind_e kind,
	input  arm_bus_pkg::motor_cfg_t  cfg,
	output logic                     sent,
	output logic                     tx_start,
	output logic [7:0]               tx_byte,
	input  logic                     busy
);
	import arm_bus_pkg::*;

	typedef enum logic [1:0] {F_IDLE, F_LOAD, F_BUSY} send_state_e;

	send_state_e state;
	frame_kind_e kind_q;
	motor_cfg_t  cfg_q;
	logic [3:0]  idx;
	logic [3:0]  last_idx;
	logic [15:0] crc;
	logic [31:0] header;
	logic [1:0]  sp_sel;

	always_comb begin
		case (kind_q)
			COMMAND: begin
				header = M3_COMMAND_HEADER;
				last_idx = 4'(M3_COMMAND_LENGTH - 1);
			end
			CONTROL_MODE: begin
				header = M3_CONTROL_MODE_HEADER;
				last_idx = 4'(M3_CONTROL_MODE_LENGTH - 1);
			end
			default: begin
				header = STATUS_REQUEST_HEADER;
				last_idx = 4'(STATUS_REQUEST_LENGTH - 1);
			end
		endcase
	end

	// control mode byte sits in front of the setpoint
	assign sp_sel = (kind_q == CONTROL_MODE) ? 2'(idx - 4'd6) : 2'(idx - 4'd5);

	always_comb begin
		if (idx < 4'(HEADER_LENGTH))
			tx_byte = header[31 - 8 * idx[1:0] -: 8];
		else if (idx == last_idx - 4'd1)
			tx_byte = crc[15:8];
		else if (idx == last_idx)
			tx_byte = crc[7:0];
		else if (idx == 4'(HEADER_LENGTH))
			tx_byte = cfg_q.id;
		else if (kind_q == CONTROL_MODE && idx == 4'd5)
			tx_byte = cfg_q.control_mode;
		else
			tx_byte = cfg_q.setpoint[8 * sp_sel +: 8]; // low byte first
	end

	assign tx_start = (state == F_LOAD);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= F_IDLE;
			idx <= '0;
			crc <= 16'hFFFF;
			sent <= 1'b0;
		end else begin
			sent <= 1'b0;
			case (state)
				F_IDLE: if (send) begin
					idx <= '0;
					crc <= 16'hFFFF;
					state <= F_LOAD;
				end
				F_LOAD: begin
					if (idx >= 4'(HEADER_LENGTH) && idx < last_idx - 4'd1)
						crc <= crc16_step(crc, tx_byte);
					state <= F_BUSY;
				end
				F_BUSY: if (!busy) begin
					if (idx == last_idx) begin
						sent <= 1'b1;
						state <= F_IDLE;
					end else begin
						idx <= idx + 4'd1;
						state <= F_LOAD;
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == F_IDLE && send) begin
			kind_q <= kind;
			cfg_q <= cfg;
		end
	end

endmodule

/* status_receiver.sv */
`timescale 1ns/1ns

module status_receiver #(
	parameter int NUM_MOTORS = 6,
	localparam int MOTOR_W = (NUM_MOTORS > 1) ? $clog2(NUM_MOTORS) : 1
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       rx_valid,
	input  logic [7:0]                 rx_byte,
	input  arm_bus_pkg::motor_cfg_t    cfg,
	input  logic [MOTOR_W-1:0]         motor,
	input  logic                       abort,
	output logic                       resp_done,
	output arm_bus_pkg::rx_result_t    result,
	output arm_bus_pkg::motor_status_t status [NUM_MOTORS],
	output arm_bus_pkg::rx_code_e      error_code [NUM_MOTORS]
);
	import arm_bus_pkg::*;

	localparam int BODY_BYTES = M3_STATUS_RESPONSE_LENGTH - HEADER_LENGTH;

	typedef enum logic [1:0] {S_HUNT, S_COLLECT, S_CHECK} recv_state_e;

	recv_state_e             state;
	logic [31:0]             last4;
	logic [8*BODY_BYTES-1:0] body; // id up to crc, first byte lowest
	logic [4:0]              cnt;
	logic [15:0]             crc;
	logic                    bad_frame;
	logic                    hdr_match;
	logic signed [31:0]      setpoint_rx;
	logic [15:0]             crc_rx;
	motor_status_t           fields;

	assign hdr_match = rx_valid && ({last4[23:0], rx_byte} == M3_STATUS_RESPONSE_HEADER);
	assign setpoint_rx = body[47:16];
	assign crc_rx = {body[183:176], body[191:184]};
	assign fields.encoder0_position = body[79:48];
	assign fields.encoder1_position = body[111:80];
	assign fields.displacement = body[143:112];
	assign fields.duty = body[175:144];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= S_HUNT;
			last4 <= '0;
			cnt <= '0;
			crc <= 16'hFFFF;
			bad_frame <= 1'b0;
			resp_done <= 1'b0;
			result <= '0;
			for (int i = 0; i < NUM_MOTORS; i++) begin
				status[i] <= '0;
				error_code[i] <= RX_OK;
			end
		end else begin
			resp_done <= 1'b0;
			if (rx_valid)
				last4 <= {last4[23:0], rx_byte};
			if (abort) begin
				// a finished bad frame keeps its code
				if (state != S_HUNT || !bad_frame)
					error_code[motor] <= RX_TIMEOUT;
				bad_frame <= 1'b0;
				state <= S_HUNT;
			end else begin
				case (state)
					S_HUNT: if (hdr_match) begin
						error_code[motor] <= RX_BUSY;
						cnt <= 5'(HEADER_LENGTH);
						crc <= 16'hFFFF;
						state <= S_COLLECT;
					end
					S_COLLECT: if (rx_valid) begin
						if (cnt < 5'(M3_STATUS_RESPONSE_LENGTH - 2))
							crc <= crc16_step(crc, rx_byte);
						if (cnt == 5'(M3_STATUS_RESPONSE_LENGTH - 1))
							state <= S_CHECK;
						cnt <= cnt + 5'd1;
					end
					S_CHECK: begin
						state <= S_HUNT;
						if (crc != crc_rx) begin
							error_code[motor] <= RX_BAD_CRC;
							bad_frame <= 1'b1;
						end else if (body[7:0] != cfg.id) begin
							error_code[motor] <= RX_WRONG_ID;
							bad_frame <= 1'b1;
						end else begin
							status[motor] <= fields;
							error_code[motor] <= RX_OK;
							resp_done <= 1'b1;
							result.ok <= 1'b1;
							result.mode_mismatch <= (body[15:8] != cfg.control_mode);
							result.setpoint_mismatch <= (setpoint_rx != cfg.setpoint);
						end
					end
					default: state <= S_HUNT;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_COLLECT && rx_valid)
			body <= {rx_byte, body[8*BODY_BYTES-1:8]};
	end

endmodule

/* bus_scheduler.sv */
`timescale 1ns/1ns

module bus_scheduler #(
	parameter int NUM_MOTORS = 6,
	parameter int UPDATE_PERIOD = 4000,
	parameter int RESPONSE_TIMEOUT = 3000,
	localparam int MOTOR_W = (NUM_MOTORS > 1) ? $clog2(NUM_MOTORS) : 1
) (
	input  logic                     clk,
	input  logic                     reset,
	input  arm_bus_pkg::motor_cfg_t  motor_cfg [NUM_MOTORS],
	output arm_bus_pkg::motor_cfg_t  cfg,
	output logic [MOTOR_W-1:0]       motor,
	output logic                     send,
	output arm_bus_pkg::frame_kind_e kind,
	input  logic                     sent,
	input  logic                     resp_done,
	input  arm_bus_pkg::rx_result_t  result,
	output logic                     abort
);
	import arm_bus_pkg::*;

	localparam int PW = $clog2(UPDATE_PERIOD);
	localparam int TW = $clog2(RESPONSE_TIMEOUT);
	localparam logic [MOTOR_W-1:0] LAST_MOTOR = MOTOR_W'(NUM_MOTORS - 1);

	sched_state_e  state;
	logic [PW-1:0] period_cnt;
	logic [TW-1:0] timeout_cnt;
	logic          tick;

	assign cfg = motor_cfg[motor];
	assign tick = (period_cnt == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			period_cnt <= PW'(UPDATE_PERIOD - 1);
		else
			period_cnt <= tick ? PW'(UPDATE_PERIOD - 1) : period_cnt - 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			motor <= LAST_MOTOR; // wraps to motor 0 on the first poll
			send <= 1'b0;
			kind <= STATUS_REQUEST;
			abort <= 1'b0;
			timeout_cnt <= '0;
		end else begin
			send <= 1'b0;
			abort <= 1'b0;
			case (state)
				IDLE: if (tick) begin
					motor <= (motor == LAST_MOTOR) ? '0 : motor + 1'b1;
					kind <= STATUS_REQUEST;
					send <= 1'b1;
					state <= REQUEST;
				end
				REQUEST: if (sent) begin
					timeout_cnt <= TW'(RESPONSE_TIMEOUT - 1); // window opens at end of request
					state <= WAIT_RESPONSE;
				end
				WAIT_RESPONSE: begin
					if (resp_done && result.ok) begin
						state <= UPDATE;
						// control mode frame also carries the setpoint
						if (result.mode_mismatch) begin
							kind <= CONTROL_MODE;
							send <= 1'b1;
						end else if (result.setpoint_mismatch) begin
							kind <= COMMAND;
							send <= 1'b1;
						end
					end else if (timeout_cnt == '0) begin
						abort <= 1'b1;
						state <= IDLE;
					end else
						timeout_cnt <= timeout_cnt - 1'b1;
				end
				UPDATE: state <= send ? WAIT_SENT : IDLE;
				WAIT_SENT: if (sent)
					state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* arm_bus_master.sv */
`timescale 1ns/1ns

module arm_bus_master #(
	parameter int NUM_MOTORS = 6,
	parameter int CLKS_PER_BIT = 8,
	parameter int UPDATE_PERIOD = 4000,
	parameter int RESPONSE_TIMEOUT = 3000,
	localparam int MOTOR_W = (NUM_MOTORS > 1) ? $clog2(NUM_MOTORS) : 1
) (
	input  logic                       clk,
	input  logic                       reset,
	output logic                       tx,
	output logic                       tx_enable,
	input  logic                       rx,
	input  arm_bus_pkg::motor_cfg_t    motor_cfg [NUM_MOTORS],
	output arm_bus_pkg::motor_status_t status [NUM_MOTORS],
	output arm_bus_pkg::rx_code_e      error_code [NUM_MOTORS]
);
	import arm_bus_pkg::*;

	motor_cfg_t         cfg;
	logic [MOTOR_W-1:0] motor;
	logic               send, sent, abort, resp_done;
	frame_kind_e        kind;
	rx_result_t         result;
	logic               tx_start, tx_busy, rx_valid;
	logic [7:0]         tx_byte, rx_byte;

	bus_scheduler #(
		.NUM_MOTORS(NUM_MOTORS),
		.UPDATE_PERIOD(UPDATE_PERIOD),
		.RESPONSE_TIMEOUT(RESPONSE_TIMEOUT)
	) u_scheduler (
		.clk, .reset, .motor_cfg, .cfg, .motor, .send, .kind,
		.sent, .resp_done, .result, .abort
	);

	frame_sender u_sender (
		.clk, .reset, .send, .kind, .cfg, .sent, .tx_start, .tx_byte, .busy(tx_busy)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
		.clk, .reset, .tx_start, .tx_byte, .busy(tx_busy), .tx, .tx_enable
	);

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
		.clk, .reset, .rx, .rx_valid, .rx_byte
	);

	status_receiver #(.NUM_MOTORS(NUM_MOTORS)) u_receiver (
		.clk, .reset, .rx_valid, .rx_byte, .cfg, .motor, .abort,
		.resp_done, .result, .status, .error_code
	);

endmodule

/* arm_bus_assert.sv */
`timescale 1ns/1ns

module bus_scheduler_assert (
	input logic                      clk,
	input logic                      reset,
	input logic                      send,
	input logic                      abort,
	input arm_bus_pkg::sched_state_e state,
	input arm_bus_pkg::frame_kind_e  kind
);
	import arm_bus_pkg::*;

	send_abort_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(send && abort))
		else $error("send and abort high in the same cycle");

	// sender is still busy with the update frame
	no_send_in_wait_sent: assert property (@(posedge clk) disable iff (reset)
		state == WAIT_SENT |-> !send)
		else $error("send raised while waiting for sent");

	request_is_status: assert property (@(posedge clk) disable iff (reset)
		(state == REQUEST && send) |-> kind == STATUS_REQUEST)
		else $error("poll send without the status request kind");

endmodule

bind bus_scheduler bus_scheduler_assert u_sched_assert (
	.clk, .reset, .send, .abort, .state, .kind
);

/* tb_arm_bus_master.sv */
`timescale 1ns/1ns

module tb_arm_bus_master;
	import arm_bus_pkg::*;

	localparam int NUM_MOTORS = 6;
	localparam int CLKS_PER_BIT = 8;
	localparam int UPDATE_PERIOD = 4000;
	localparam int NUM_POLLS = 30;
	localparam int BYTE_GAP = 16; // cycles allowed between two bytes of one frame
	localparam logic [31:0] SEED = 32'h42f0_739f;

	typedef enum int {GOOD, BAD_CRC, WRONG_ID, SILENT} reply_e;

	logic          clk = 1'b0;
	logic          reset;
	logic          tx;
	logic          tx_enable;
	logic          rx;
	motor_cfg_t    motor_cfg [NUM_MOTORS];
	motor_status_t status [NUM_MOTORS];
	rx_code_e      error_code [NUM_MOTORS];

	motor_status_t exp_status [NUM_MOTORS];
	rx_code_e      exp_code [NUM_MOTORS];
	logic [7:0]    frame_bytes [$]; // last frame seen on tx
	logic [7:0]    build_q [$];     // frame built by the motor model
	logic [15:0]   build_crc;
	int            cycle = 0;
	int            start_cycle;
	int            frame_cycle;
	int            checks;
	int            errors;
	int            timeouts;
	bit            timed_out;

	arm_bus_master #(.NUM_MOTORS(NUM_MOTORS)) DUT (
		.clk, .reset, .tx, .tx_enable, .rx, .motor_cfg, .status, .error_code
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic compare_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// crc-16 ccitt, shifted one bit at a time
	function automatic logic [15:0] crc_add(input logic [15:0] crc, input logic [7:0] b);
		logic [15:0] c;
		logic [7:0]  d;
		logic        fb;
		c = crc;
		d = b;
		repeat (8) begin
			fb = c[15] ^ d[7];
			c = {c[14:0], 1'b0};
			if (fb)
				c = c ^ 16'h1021;
			d = {d[6:0], 1'b0};
		end
		return c;
	endfunction

	task automatic start_frame(input logic [31:0] header);
		build_q.delete();
		build_crc = 16'hFFFF;
		build_q.push_back(header[31:24]);
		build_q.push_back(header[23:16]);
		build_q.push_back(header[15:8]);
		build_q.push_back(header[7:0]);
	endtask

	task automatic add_byte(input logic [7:0] b);
		build_q.push_back(b);
		build_crc = crc_add(build_crc, b);
	endtask

	task automatic add_word(input logic [31:0] w); // low byte first
		add_byte(w[7:0]);
		add_byte(w[15:8]);
		add_byte(w[23:16]);
		add_byte(w[31:24]);
	endtask

	task automatic end_frame;
		build_q.push_back(build_crc[15:8]);
		build_q.push_back(build_crc[7:0]);
	endtask

	task automatic expected_frame(input frame_kind_e kind, input motor_cfg_t c);
		case (kind)
			COMMAND: start_frame(M3_COMMAND_HEADER);
			CONTROL_MODE: start_frame(M3_CONTROL_MODE_HEADER);
			default: start_frame(STATUS_REQUEST_HEADER);
		endcase
		add_byte(c.id);
		if (kind == CONTROL_MODE)
			add_byte(c.control_mode);
		if (kind != STATUS_REQUEST)
			add_word(c.setpoint);
		end_frame();
	endtask

	// samples one 8N1 byte from tx at mid-bit
	task automatic read_byte(input int limit, output logic [7:0] b);
		int n;
		b = '0;
		n = 0;
		while (tx !== 1'b0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (tx !== 1'b0) begin
			timed_out = 1'b1;
			timeouts++;
			$display("timeout: no start bit on tx within %0d cycles", limit);
		end else begin
			start_cycle = cycle;
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			compare_value("tx_enable in start bit", 128'(1'b1), 128'(tx_enable));
			repeat (8) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				b = {tx, b[7:1]};
				compare_value("tx_enable in data bit", 128'(1'b1), 128'(tx_enable));
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			compare_value("stop bit on tx", 128'(1'b1), 128'(tx));
		end
	endtask

	task automatic get_frame(input int first_limit);
		logic [7:0]  b;
		logic [31:0] header;
		int          len;
		frame_bytes.delete();
		len = HEADER_LENGTH;
		while (!timed_out && frame_bytes.size() < len) begin
			read_byte((frame_bytes.size() == 0) ? first_limit : BYTE_GAP, b);
			if (!timed_out)
				frame_bytes.push_back(b);
			if (frame_bytes.size() == 1)
				frame_cycle = start_cycle;
			if (frame_bytes.size() == HEADER_LENGTH) begin
				header = {frame_bytes[0], frame_bytes[1], frame_bytes[2], frame_bytes[3]};
				case (header)
					STATUS_REQUEST_HEADER: len = STATUS_REQUEST_LENGTH;
					M3_COMMAND_HEADER: len = M3_COMMAND_LENGTH;
					M3_CONTROL_MODE_HEADER: len = M3_CONTROL_MODE_LENGTH;
					default: $display("unknown frame header %h on tx", header);
				endcase
			end
		end
	endtask

	task automatic compare_frame(input string what);
		int i;
		compare_value({what, " length"}, 128'(build_q.size()), 128'(frame_bytes.size()));
		for (i = 0; i < build_q.size() && i < frame_bytes.size(); i++)
			compare_value($sformatf("%s byte %0d", what, i), 128'(build_q[i]),
				128'(frame_bytes[i]));
	endtask

	task automatic check_state(input string when);
		int i;
		for (i = 0; i < NUM_MOTORS; i++) begin
			compare_value($sformatf("%s status[%0d]", when, i), exp_status[i], status[i]);
			compare_value($sformatf("%s error_code[%0d]", when, i), 128'(exp_code[i]),
				128'(error_code[i]));
		end
	endtask

	task automatic drive_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		repeat (10) begin
			rx = bits[0];
			bits = bits >> 1;
			repeat (CLKS_PER_BIT) @(negedge clk);
			compare_value("tx_enable while replying", 128'(1'b0), 128'(tx_enable));
		end
	endtask

	// one motor board answering a poll, updates the model
	task automatic play_reply(input int m, input reply_e kind, output bit due,
			output frame_kind_e next_kind);
		motor_cfg_t    c;
		motor_status_t s;
		logic [7:0]    mode;
		logic [31:0]   setpoint;
		int            i;
		c = motor_cfg[m];
		mode = c.control_mode;
		setpoint = c.setpoint;
		if ($urandom % 3 == 0)
			mode = mode ^ (8'($urandom) | 8'h01);
		if ($urandom % 3 == 0)
			setpoint = setpoint ^ ($urandom | 32'h1);
		s.encoder0_position = $urandom;
		s.encoder1_position = $urandom;
		s.displacement = $urandom;
		s.duty = $urandom;
		start_frame(M3_STATUS_RESPONSE_HEADER);
		add_byte((kind == WRONG_ID) ? (c.id ^ 8'h55) : c.id);
		add_byte(mode);
		add_word(setpoint);
		add_word(s.encoder0_position);
		add_word(s.encoder1_position);
		add_word(s.displacement);
		add_word(s.duty);
		end_frame();
		if (kind == BAD_CRC)
			build_q[build_q.size() - 1] = build_q[build_q.size() - 1] ^ 8'h5A;
		due = 1'b0;
		next_kind = STATUS_REQUEST;
		case (kind)
			GOOD: begin
				exp_status[m] = s;
				exp_code[m] = RX_OK;
				if (mode != c.control_mode) begin
					due = 1'b1;
					next_kind = CONTROL_MODE; // mode change wins over setpoint
				end else if (setpoint != c.setpoint) begin
					due = 1'b1;
					next_kind = COMMAND;
				end
			end
			BAD_CRC: exp_code[m] = RX_BAD_CRC;
			WRONG_ID: exp_code[m] = RX_WRONG_ID;
			default: exp_code[m] = RX_TIMEOUT;
		endcase
		if (kind != SILENT) begin
			repeat (10) @(negedge clk); // bus turnaround
			for (i = 0; i < build_q.size(); i++)
				drive_byte(build_q[i]);
		end
	endtask

	initial begin
		int          i;
		int          r;
		int          m;
		int          poll;
		int          reset_cycle;
		int          delay;
		bit          due;
		frame_kind_e next_kind;
		reply_e      choice;
		void'($urandom(SEED));
		reset = 1'b1;
		rx = 1'b1;
		timed_out = 1'b0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		for (i = 0; i < NUM_MOTORS; i++) begin
			motor_cfg[i].id = {5'($urandom), 3'(i)}; // low bits keep ids distinct
			motor_cfg[i].control_mode = 8'($urandom);
			motor_cfg[i].setpoint = $urandom;
			exp_status[i] = '0;
			exp_code[i] = RX_OK;
		end
		repeat (3) @(negedge clk);
		compare_value("tx in reset", 128'(1'b1), 128'(tx));
		compare_value("tx_enable in reset", 128'(1'b0), 128'(tx_enable));
		reset = 1'b0;
		reset_cycle = cycle;
		check_state("after reset");

		m = 0;
		for (poll = 0; poll <= NUM_POLLS && !timed_out; poll++) begin
			get_frame(2 * UPDATE_PERIOD);
			if (timed_out)
				break;
			if (poll == 0) begin
				delay = frame_cycle - reset_cycle;
				compare_value($sformatf("first poll after %0d cycles", delay), 128'(1'b1),
					128'(delay >= UPDATE_PERIOD && delay <= UPDATE_PERIOD + 4));
			end
			check_state($sformatf("poll %0d", poll));
			expected_frame(STATUS_REQUEST, motor_cfg[m]);
			compare_frame($sformatf("poll %0d request", poll));
			if (poll == NUM_POLLS)
				break;
			r = $urandom % 6;
			choice = (r < 3) ? GOOD : reply_e'(r - 2);
			play_reply(m, choice, due, next_kind);
			if (due) begin
				get_frame(400);
				if (timed_out)
					break;
				expected_frame(next_kind, motor_cfg[m]);
				compare_frame($sformatf("poll %0d update", poll));
			end
			m = (m + 1) % NUM_MOTORS;
		end

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

/* project.f */
arm_bus_pkg.sv
uart_tx.sv
uart_rx.sv
frame_sender.sv
status_receiver.sv
bus_scheduler.sv
arm_bus_master.sv
arm_bus_assert.sv
tb_arm_bus_master.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_arm_bus_master

# the simulation result is taken from the log below
./obj_dir/Vtb_arm_bus_master > sim.log 2>&1 || true
cat sim.log

grep -qF '*** PASSED ***' sim.log
